// File: filelist.f
+incdir+include
source/rs485Pkg.sv
source/frameRegs.sv
source/frameMem.sv
source/rs485Tx.sv
source/rs485Top.sv
tests/clockGen.sv
tests/rs485Tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the rs485 testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
	--top-module rs485Tb -o rs485Sim \
	&& ./obj_dir/rs485Sim > sim.log 2>&1 \
	|| { echo "build or simulation run failed"; exit 1; }
grep -qF "*** TEST FAILED ***" sim.log \
	&& { echo "simulation reported a failure, see sim.log"; exit 1; } \
	|| { echo "simulation finished clean, see sim.log"; exit 0; }

// File: tests/rs485Tb.sv
`default_nettype none

`include "rs485_defs.svh"

module rs485Tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [1:0] lineTx    = 2'd0; // bit positions in line
	localparam logic [1:0] lineDirTx = 2'd1;
	localparam logic [1:0] lineDirRx = 2'd2;

	logic           edgeTx;
	logic           reset;
	rs485Pkg::wbReq bus;
	rs485Pkg::wbRsp busRsp;
	logic           tx;
	logic           dirTx;
	logic           dirRx;
	logic [2:0]     line;
	logic [7:0]     memModel [`FRAME_DEPTH]; // bytes the host has written
	logic [31:0]    lcgState = 32'hbd37_feb4;
	int             errors = 0;
	int             timeouts = 0;
	int             n;

	assign line = {dirRx, dirTx, tx};

	clockGen i_clk (.edgeTx(edgeTx), .reset(reset));

	rs485Top i_dut (
		.edgeTx (edgeTx),
		.reset  (reset),
		.bus    (bus),
		.busRsp (busRsp),
		.tx     (tx),
		.dirTx  (dirTx),
		.dirRx  (dirRx)
	);

	function automatic logic [7:0] nextRandByte();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:24]; // upper byte of the state
	endfunction

	task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %s got %0h expected %0h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	// one wishbone classic cycle with ack expected on the first negedge
	task automatic wbAccess(input logic we, input logic [`WB_ADDR_BITS-1:0] adr,
			input logic [7:0] wdat, output logic [7:0] rdat);
		int waits;
		waits = 0;
		bus = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		@(negedge edgeTx);
		waits++;
		while (!busRsp.ack && waits < 8) begin
			@(negedge edgeTx);
			waits++;
		end
		assert (busRsp.ack) else begin
			$display("bus access to %0h never acknowledged", adr);
			timeouts++;
		end
		expectEq("ack latency", waits, 1);
		rdat = busRsp.dat;
		bus = '0;
		@(negedge edgeTx);
		expectEq("busRsp.ack", 32'(busRsp.ack), 0); // exactly one ack
	endtask

	task automatic wbWrite(input logic [`WB_ADDR_BITS-1:0] adr, input logic [7:0] wdat);
		logic [7:0] unused;
		wbAccess(1'b1, adr, wdat, unused);
	endtask

	task automatic wbRead(input logic [`WB_ADDR_BITS-1:0] adr, output logic [7:0] rdat);
		wbAccess(1'b0, adr, 8'h00, rdat);
	endtask

	// counts negedges until a line signal takes a value (0 if it already has it)
	task automatic cyclesUntil(input logic [1:0] idx, input logic val, input string what,
			output int cnt);
		cnt = 0;
		while (line[idx] !== val && cnt < 200) begin
			@(negedge edgeTx);
			cnt++;
		end
		assert (line[idx] === val) else begin
			$display("gave up waiting for %s", what);
			timeouts++;
		end
	endtask

	// serial decoder expecting bytes in memory order
	task automatic recvFrame(input int count);
		logic [7:0] data;
		int         cnt;
		for (int b = 0; b < count; b++) begin
			if (b == 0) begin
				cyclesUntil(lineTx, 1'b0, "start bit", cnt);
			end else begin
				@(negedge edgeTx);
				expectEq("tx start bit", 32'(tx), 0); // no idle bit between bytes
			end
			repeat (8) begin
				@(negedge edgeTx);
				data = {tx, data[7:1]}; // lsb arrives first
				expectEq("dirTx", 32'(dirTx), 1);
			end
			@(negedge edgeTx);
			expectEq("tx stop bit", 32'(tx), 1);
			expectEq("tx byte", 32'(data), 32'(memModel[5'(b)]));
		end
		@(negedge edgeTx);
		expectEq("dirTx", 32'(dirTx), 0); // released right after last stop
		cyclesUntil(lineDirRx, 1'b0, "dirRx fall", cnt);
		expectEq("dirRx tail", cnt, `DIR_TAIL);
	endtask

	task automatic expectQuiet(input int cycles);
		repeat (cycles) begin
			@(negedge edgeTx);
			expectEq("tx", 32'(tx), 1);
			expectEq("dirTx", 32'(dirTx), 0);
			expectEq("dirRx", 32'(dirRx), 0);
		end
	endtask

	// poll for done then write one to clear it
	task automatic finishStatus();
		logic [7:0] stat;
		int         polls;
		stat = 8'h00;
		polls = 0;
		while (!stat[1] && polls < 20) begin
			wbRead(`REG_STAT, stat);
			polls++;
		end
		assert (stat[1]) else begin
			$display("done flag never set after the frame");
			timeouts++;
		end
		expectEq("STAT", 32'(stat), 32'h02); // done and not busy
		wbWrite(`REG_STAT, 8'h02);
		wbRead(`REG_STAT, stat);
		expectEq("STAT", 32'(stat), 0);
	endtask

	task automatic resetState();
		logic [7:0] stat;
		expectEq("tx", 32'(tx), 1);
		expectEq("dirTx", 32'(dirTx), 0);
		expectEq("dirRx", 32'(dirRx), 0);
		expectEq("busRsp.ack", 32'(busRsp.ack), 0);
		wbRead(`REG_STAT, stat);
		expectEq("STAT", 32'(stat), 0);
	endtask

	task automatic regAccess();
		logic [7:0] rd;
		wbWrite(`REG_CTRL, 8'h13); // length only
		wbRead(`REG_CTRL, rd);
		expectEq("CTRL", 32'(rd), 32'h13);
		memModel[5] = 8'ha5;
		wbWrite(6'h05, 8'ha5); // nonzero byte in the frame region
		wbRead(6'h05, rd);
		expectEq("frame mem read", 32'(rd), 0); // host cannot read it back
		expectQuiet(20);
		wbRead(`REG_STAT, rd);
		expectEq("STAT", 32'(rd), 0);
	endtask

	task automatic singleByte();
		int cnt;
		memModel[0] = 8'h5a;
		wbWrite(6'h00, 8'h5a);
		wbWrite(`REG_CTRL, 8'h80); // start with length field 0
		cyclesUntil(lineDirRx, 1'b1, "dirRx rise", cnt);
		expectEq("dirRx after start", cnt, 0); // receiver already off
		cyclesUntil(lineDirTx, 1'b1, "dirTx rise", cnt);
		expectEq("dirTx lead", cnt, `DIR_LEAD);
		cyclesUntil(lineTx, 1'b0, "first start bit", cnt);
		expectEq("tx start lead", cnt, `DIR_LEAD);
		recvFrame(1);
		expectQuiet(10); // only one character
		finishStatus();
	endtask

	task automatic fullFrame();
		for (int i = 0; i < `FRAME_DEPTH; i++) begin
			memModel[5'(i)] = nextRandByte();
			wbWrite(6'(i), memModel[5'(i)]);
		end
		wbWrite(`REG_CTRL, 8'h80 + 8'(`FRAME_DEPTH - 1));
		recvFrame(`FRAME_DEPTH);
		finishStatus();
	endtask

	task automatic statusHandshake();
		logic [7:0] stat;
		wbWrite(`REG_CTRL, 8'h80);
		wbRead(`REG_STAT, stat); // still in the lead time
		expectEq("STAT", 32'(stat), 32'h01);
		recvFrame(1);
		finishStatus();
	endtask

	task automatic startWhileBusy();
		wbWrite(`REG_CTRL, 8'h81); // two bytes
		wbWrite(`REG_CTRL, 8'h85); // lands in DIRON and must be dropped
		recvFrame(2);
		finishStatus();
		expectQuiet(40); // no second frame
	endtask

	initial begin
		bus = '0;
		n = 0;
		while (reset !== 1'b1 && n < 50) begin
			@(negedge edgeTx);
			n++;
		end
		assert (reset === 1'b1) else begin
			$display("reset was never released");
			timeouts++;
		end
		@(negedge edgeTx);
		resetState();
		regAccess();
		singleByte();
		fullFrame();
		statusHandshake();
		startWhileBusy();
		$display("closing report: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/clockGen.sv
`default_nettype none

module clockGen (
	output logic edgeTx,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		edgeTx = 1'b0;
		forever #2 edgeTx = ~edgeTx; // 4 ns bit period
	end

	// low across five rising edges, released clear of any edge
	initial begin
		reset = 1'b0;
		repeat (5) @(posedge edgeTx);
		@(negedge edgeTx);
		#1 reset = 1'b1;
	end

endmodule

`default_nettype wire

// File: source/rs485Top.sv
`default_nettype none

module rs485Top (
	input  logic           edgeTx, // bit clock, one bit per cycle
	input  logic           reset,
	input  rs485Pkg::wbReq bus,
	output rs485Pkg::wbRsp busRsp,
	output logic           tx,
	output logic           dirTx, // driver enable
	output logic           dirRx  // high keeps the receiver off
);

	rs485Pkg::memWrite memWr;
	rs485Pkg::fetchReq fetch;
	rs485Pkg::fetchRsp fetchRsp;
	logic              start;
	logic [4:0]        frameLen;
	logic              busy;
	logic              doneEvent;

	// host side, decode and status
	frameRegs i_regs (
		.edgeTx    (edgeTx),
		.reset     (reset),
		.bus       (bus),
		.busRsp    (busRsp),
		.memWr     (memWr),
		.start     (start),
		.frameLen  (frameLen),
		.busy      (busy),
		.doneEvent (doneEvent)
	);

	frameMem i_mem (
		.edgeTx   (edgeTx),
		.reset    (reset),
		.memWr    (memWr),
		.fetch    (fetch),
		.fetchRsp (fetchRsp)
	);

	// line side
	rs485Tx i_tx (
		.edgeTx    (edgeTx),
		.reset     (reset),
		.start     (start),
		.frameLen  (frameLen),
		.fetch     (fetch),
		.fetchRsp  (fetchRsp),
		.busy      (busy),
		.doneEvent (doneEvent),
		.tx        (tx),
		.dirTx     (dirTx),
		.dirRx     (dirRx)
	);

endmodule

`default_nettype wire

// File: source/rs485Tx.sv
`default_nettype none

`include "rs485_defs.svh"

module rs485Tx (
	input  logic              edgeTx,
	input  logic              reset,
	input  logic              start,
	input  logic [4:0]        frameLen,
	output rs485Pkg::fetchReq fetch,
	input  rs485Pkg::fetchRsp fetchRsp,
	output logic              busy,
	output logic              doneEvent,
	output logic              tx,
	output logic              dirTx,
	output logic              dirRx
);

	// delay counter compare points
	localparam logic [5:0] dirTxAt  = 6'(`DIR_LEAD - 1);
	localparam logic [5:0] dirOnEnd = 6'(2 * `DIR_LEAD - 1);
	localparam logic [5:0] tailEnd  = 6'(`DIR_TAIL - 1);

	rs485Pkg::txState state;
	logic [5:0]       dly;      // turn-around timing
	logic [3:0]       bitCnt;   // 0 start, 1..8 data, 9 stop
	logic [4:0]       byteIdx;  // byte on the line
	logic [4:0]       lastIdx;  // length latched at start
	logic             reqQ;
	logic [4:0]       addrQ;
	logic [7:0]       shiftBuf;

	assign busy  = (state != rs485Pkg::IDLE);
	assign fetch = '{req: reqQ, addr: addrQ};

	// byte buffer, loaded on ack, shifted lsb first
	// next ack only lands in the stop bit or in FETCH, so no clash with shifting
	always_ff @(posedge edgeTx) begin
		if (reqQ && fetchRsp.ack) begin
			shiftBuf <= fetchRsp.data;
		end else if (state == rs485Pkg::SHIFT && bitCnt < 4'd8) begin
			shiftBuf <= shiftBuf >> 1;
		end
	end

	always_ff @(posedge edgeTx or negedge reset) begin
		if (!reset) begin
			state     <= rs485Pkg::IDLE;
			dly       <= '0;
			bitCnt    <= '0;
			byteIdx   <= '0;
			lastIdx   <= '0;
			reqQ      <= 1'b0;
			addrQ     <= '0;
			tx        <= 1'b1; // line idles high
			dirTx     <= 1'b0;
			dirRx     <= 1'b0;
			doneEvent <= 1'b0;
		end else begin
			doneEvent <= 1'b0;
			if (reqQ && fetchRsp.ack) begin
				reqQ <= 1'b0; // handshake done
			end
			case (state)
				rs485Pkg::IDLE: begin
					if (start) begin // ignored while busy, we are not in IDLE then
						dirRx   <= 1'b1; // receiver off first
						dly     <= '0;
						byteIdx <= '0;
						lastIdx <= frameLen;
						reqQ    <= 1'b1; // first fetch hides in the lead time
						addrQ   <= '0;
						state   <= rs485Pkg::DIRON;
					end
				end
				rs485Pkg::DIRON: begin
					dly <= dly + 6'd1;
					if (dly == dirTxAt) begin
						dirTx <= 1'b1; // driver on
					end
					if (dly == dirOnEnd) begin
						bitCnt <= '0;
						if (!reqQ || fetchRsp.ack) begin
							tx    <= 1'b0; // first start bit
							state <= rs485Pkg::SHIFT;
						end else begin
							state <= rs485Pkg::FETCH; // memory still owes the byte
						end
					end
				end
				rs485Pkg::FETCH: begin
					// line stays high until the byte shows up
					if (fetchRsp.ack) begin
						tx     <= 1'b0;
						bitCnt <= '0;
						state  <= rs485Pkg::SHIFT;
					end
				end
				rs485Pkg::SHIFT: begin
					bitCnt <= bitCnt + 4'd1;
					if (bitCnt < 4'd8) begin
						tx <= shiftBuf[0]; // data bit
						// last data bit going out, ask for the next byte
						// so its ack falls in the stop bit
						if (bitCnt == 4'd7 && byteIdx != lastIdx) begin
							reqQ  <= 1'b1;
							addrQ <= byteIdx + 5'd1;
						end
					end else if (bitCnt == 4'd8) begin
						tx <= 1'b1; // stop bit
					end else begin
						bitCnt <= '0;
						if (byteIdx == lastIdx) begin
							dirTx <= 1'b0; // frame over
							dly   <= '0;
							state <= rs485Pkg::DIROFF;
						end else begin
							byteIdx <= byteIdx + 5'd1;
							if (fetchRsp.ack) begin
								tx <= 1'b0; // back to back, no idle bit
							end else begin
								state <= rs485Pkg::FETCH;
							end
						end
					end
				end
				rs485Pkg::DIROFF: begin
					dly <= dly + 6'd1;
					if (dly == tailEnd) begin
						dirRx     <= 1'b0; // listening again
						doneEvent <= 1'b1;
						state     <= rs485Pkg::IDLE;
					end
				end
				default: state <= rs485Pkg::IDLE;
			endcase
		end
	end

	// bus is only ever pulled low with the driver enabled
	txNeedsDriver: assert property (@(posedge edgeTx) disable iff (!reset)
		!tx |-> dirTx);
	// driver and receiver never both on
	driverNeedsRxOff: assert property (@(posedge edgeTx) disable iff (!reset)
		dirTx |-> dirRx);

endmodule

`default_nettype wire

// File: source/frameMem.sv
`default_nettype none

`include "rs485_defs.svh"

module frameMem (
	input  logic              edgeTx,
	input  logic              reset,
	input  rs485Pkg::memWrite memWr,
	input  rs485Pkg::fetchReq fetch,
	output rs485Pkg::fetchRsp fetchRsp
);

	logic [7:0] mem [`FRAME_DEPTH]; // frame bytes
	logic [7:0] dataQ;
	logic       ackQ;

	// host write port
	always_ff @(posedge edgeTx) begin
		if (memWr.en) begin
			mem[memWr.addr] <= memWr.data;
		end
	end

	// fetch data, one cycle after req
	always_ff @(posedge edgeTx) begin
		if (fetch.req) begin
			dataQ <= mem[fetch.addr];
		end
	end

	// single-cycle ack per request
	// transmitter drops req on the ack edge, so !ackQ stops a second one
	always_ff @(posedge edgeTx or negedge reset) begin
		if (!reset) begin
			ackQ <= 1'b0;
		end else begin
			ackQ <= fetch.req && !ackQ; // low whenever req is low
		end
	end

	assign fetchRsp = '{ack: ackQ, data: dataQ};

endmodule

`default_nettype wire

// File: source/frameRegs.sv
`default_nettype none

`include "rs485_defs.svh"

module frameRegs (
	input  logic              edgeTx,
	input  logic              reset,
	input  rs485Pkg::wbReq    bus,
	output rs485Pkg::wbRsp    busRsp,
	output rs485Pkg::memWrite memWr,
	output logic              start,
	output logic [4:0]        frameLen,
	input  logic              busy,
	input  logic              doneEvent
);

	localparam int memAw = $clog2(`FRAME_DEPTH);

	rs485Pkg::regSel sel;
	logic            ackQ;
	logic            doneQ; // sticky until host clears it
	logic            access;
	logic            wrAccess;
	logic [7:0]      rdData;

	// address decode
	always_comb begin
		if (bus.adr < `FRAME_DEPTH) begin
			sel = rs485Pkg::MEM;
		end else if (bus.adr == `REG_CTRL) begin
			sel = rs485Pkg::CTRL;
		end else if (bus.adr == `REG_STAT) begin
			sel = rs485Pkg::STAT;
		end else begin
			sel = rs485Pkg::NONE; // unmapped, reads zero
		end
	end

	// first cycle of cyc&stb only, ack comes next cycle
	assign access   = bus.cyc && bus.stb && !ackQ;
	assign wrAccess = access && bus.we;

	// frame bytes go straight through, memory latches on the same edge as ack
	assign memWr = '{
		en:   wrAccess && (sel == rs485Pkg::MEM),
		addr: bus.adr[memAw-1:0],
		data: bus.dat
	};

	always_ff @(posedge edgeTx or negedge reset) begin
		if (!reset) begin
			ackQ     <= 1'b0;
			start    <= 1'b0;
			frameLen <= '0;
			doneQ    <= 1'b0;
		end else begin
			ackQ  <= access; // never stalls
			start <= wrAccess && (sel == rs485Pkg::CTRL) && bus.dat[7]; // one cycle
			if (wrAccess && (sel == rs485Pkg::CTRL)) begin
				frameLen <= bus.dat[4:0];
			end
			// new completion beats a clear in the same cycle
			if (doneEvent) begin
				doneQ <= 1'b1;
			end else if (wrAccess && (sel == rs485Pkg::STAT) && bus.dat[1]) begin
				doneQ <= 1'b0; // write one to clear
			end
		end
	end

	// read mux, registered with ack
	always_ff @(posedge edgeTx) begin
		if (access) begin
			if (bus.we) begin
				rdData <= 8'h00;
			end else begin
				case (sel)
					rs485Pkg::CTRL: rdData <= {3'b000, frameLen}; // start reads 0
					rs485Pkg::STAT: rdData <= {6'd0, doneQ, busy};
					default:        rdData <= 8'h00; // memory not readable
				endcase
			end
		end
	end

	assign busRsp = '{ack: ackQ, dat: rdData};

	// ack only answers a request seen the cycle before
	ackAfterReq: assert property (@(posedge edgeTx) disable iff (!reset)
		ackQ |-> $past(bus.cyc && bus.stb));

endmodule

`default_nettype wire

// File: source/rs485Pkg.sv
`default_nettype none

`include "rs485_defs.svh"

package rs485Pkg;

	// wishbone classic request, host to slave
	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		logic [`WB_ADDR_BITS-1:0] adr;
		logic [7:0]               dat;
	} wbReq;

	typedef struct packed {
		logic       ack; // one cycle per access
		logic [7:0] dat;
	} wbRsp;

	// register block into frame memory
	typedef struct packed {
		logic                            en;
		logic [$clog2(`FRAME_DEPTH)-1:0] addr;
		logic [7:0]                      data;
	} memWrite;

	// byte fetch, transmitter side
	typedef struct packed {
		logic                            req; // held until ack
		logic [$clog2(`FRAME_DEPTH)-1:0] addr;
	} fetchReq;

	typedef struct packed {
		logic       ack;
		logic [7:0] data;
	} fetchRsp;

	typedef enum logic [2:0] {IDLE, DIRON, FETCH, SHIFT, DIROFF} txState;

	// address decode result
	typedef enum logic [1:0] {CTRL, STAT, MEM, NONE} regSel;

endpackage

`default_nettype wire

// File: include/rs485_defs.svh
`ifndef RS485_DEFS_SVH
`define RS485_DEFS_SVH

// host bus address width, covers memory plus the two registers
`define WB_ADDR_BITS 6

// frame memory size in bytes, mapped at 0x00..0x1F
`define FRAME_DEPTH 32

// turn-around delays in bit cycles
`define DIR_LEAD 15 // rx off -> driver on, and driver on -> first start bit
`define DIR_TAIL 4  // driver off -> rx back on

// register addresses above the frame region
`define REG_CTRL 6'h20 // start bit 7, length 4:0
`define REG_STAT 6'h21 // busy bit 0, done bit 1

`endif
